//--- project.f
src/cmt_pkg.sv
src/cmt_select.sv
src/cmt_redirect.sv
src/cmt_seq.sv
src/cmt_epu.sv
src/cmt_top.sv
verification/cmt_chk.sv
verification/cmt_tb.sv

//--- Makefile
# Verilator lint and simulation of the commit stage

VERILATOR ?= verilator
TOP       ?= cmt_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/cmt_tb.sv
/*
 * Commit stage testbench
 * LFSR driven reorder buffer windows, a memory responder and a
 * cycle model of the commit, redirect and exception rules
 */
module cmt_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import cmt_pkg::*;

   localparam int    CLK_PERIOD = 40;
   localparam int    N_TXN      = 1500;              // Modelled cycles
   localparam int    WDOG_CYC   = 2000 + 8 * N_TXN;
   localparam data_t RDATA_XOR  = 32'h5a3c_96e1;

   logic                  clk;
   logic                  rst;
   cmt_lane_t [CMT_W-1:0] lanes;
   mem_resp_t             mem_resp;
   logic [CMT_W-1:0]      fire;
   logic [CMT_CNT_W-1:0]  pop_size;
   redirect_t             redirect;
   prf_wr_t               prf_wr;
   bpu_upd_t              bpu_upd;
   mem_req_t              mem_req;

   logic [31:0]           lfsr;
   cmt_lane_t [CMT_W-1:0] win;          // Reorder buffer head as the model sees it
   logic                  se_pend;      // Mispredict flush due this cycle
   pc_t                   se_tgt;
   logic                  epu_pend;     // Exception unit answers this cycle
   epu_op_e               epu_op_q;
   logic                  epu_exc_q;
   logic                  st_pend;      // Long op in flight
   pc_t                   epc;
   int                    mem_wait;
   data_t                 mem_addr;

   logic [CMT_W-1:0]      exp_fire;
   logic [CMT_CNT_W-1:0]  exp_pop;
   redirect_t             exp_redir;
   prf_wr_t               exp_prf;
   bpu_upd_t              exp_bpu;
   mem_req_t              exp_mem;
   int                    n_fire;
   logic                  exc_fl;
   logic                  issue;
   logic                  finish;
   int                    n_se;
   int                    n_exc;
   int                    n_mem;
   int                    n_wb;

   cmt_top i_cmt_top (
      .clk      (clk),
      .rst      (rst),
      .lanes    (lanes),
      .mem_resp (mem_resp),
      .fire     (fire),
      .pop_size (pop_size),
      .redirect (redirect),
      .prf_wr   (prf_wr),
      .bpu_upd  (bpu_upd),
      .mem_req  (mem_req)
   );

   bind cmt_top cmt_chk u_chk (
      .clk      (clk),
      .rst      (rst),
      .lanes    (lanes),
      .fire     (fire),
      .redirect (redirect),
      .mem_req  (mem_req),
      .mem_resp (mem_resp)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int k = 0; k < n; k++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   // At most one of load/store, EPU op or exc per entry
   function automatic cmt_lane_t new_lane();
      cmt_lane_t  l;
      logic [3:0] kind;
      logic [1:0] bsel;
      l       = '0;
      l.valid = (rand_bits(3) != 0);
      kind    = 4'(rand_bits(4));
      l.pc    = pc_t'(rand_bits(PC_W));
      l.prd   = prf_addr_t'(rand_bits(PRF_AW));
      l.opera = rand_bits(DW);
      l.operb = rand_bits(DW);
      case (kind)
         4'd8:  l.lsu_op = LSU_LOAD;
         4'd9:  l.lsu_op = LSU_STORE;
         4'd10, 4'd11:
         begin
            bsel         = 2'(rand_bits(2));
            l.is_bcc     = (bsel == 2'd0);
            l.is_brel    = (bsel == 2'd1);
            l.is_breg    = bsel[1];
            l.pred_taken = 1'(rand_bits(1));
            l.pred_tgt   = pc_t'(rand_bits(PC_W));
            l.fls        = (kind == 4'd11);       // Mispredicted branch
            l.fls_tgt    = pc_t'(rand_bits(PC_W));
         end
         4'd12: l.epu_op = EPU_SYSCALL;
         4'd13: l.exc    = 1'b1;
         4'd14: l.epu_op = EPU_ERET;
         4'd15: l.epu_op = EPU_RDEPC;
         default: ;
      endcase
      if (kind <= 4'd8 || kind == 4'd15)
         l.prd_we = 1'(rand_bits(1));             // Only ops with a result
      return l;
   endfunction

   // Empty slots get new entries, valid lanes stay packed from lane 0
   task automatic refill_window();
      logic gap;
      gap = 1'b0;
      for (int i = 0; i < CMT_W; i++)
      begin
         if (!win[i].valid)
            win[i] = new_lane();
         if (!win[i].valid)
            gap = 1'b1;
         else if (gap)
            win[i].valid = 1'b0;
      end
   endtask

   function automatic logic single_issue(input cmt_lane_t l);
      logic long_req;
      long_req = !se_pend && (l.lsu_op != LSU_NONE || l.epu_op != EPU_NONE || l.exc);
      return long_req || l.fls || l.is_bcc || l.is_brel || l.is_breg;
   endfunction

   task automatic drive_inputs();
      lanes    = win;
      mem_resp = '0;
      if (mem_wait > 0)
      begin
         mem_wait--;
         if (mem_wait == 0)
         begin
            mem_resp.valid = 1'b1;
            mem_resp.rdata = mem_addr ^ RDATA_XOR;
         end
      end
   endtask

   task automatic predict();
      logic stop;
      logic long0;
      logic eret_fl;
      int   n_ready;
      n_ready = 0;
      stop    = 1'b0;
      for (int i = 0; i < CMT_W; i++)
      begin
         if (!stop && win[i].valid && !(i > 0 && single_issue(win[i])))
         begin
            n_ready++;
            stop = single_issue(win[i]);          // Lane 0 alone
         end
         else
            stop = 1'b1;
      end
      long0   = n_ready > 0 && !se_pend &&
                (win[0].lsu_op != LSU_NONE || win[0].epu_op != EPU_NONE || win[0].exc);
      finish  = mem_resp.valid || epu_pend;
      exc_fl  = epu_pend && (epu_exc_q || epu_op_q == EPU_SYSCALL);
      eret_fl = epu_pend && !epu_exc_q && epu_op_q == EPU_ERET;
      issue   = !st_pend && long0;

      exp_redir.flush = se_pend || exc_fl || eret_fl;
      if (se_pend)
         exp_redir.tgt = se_tgt;
      else if (exc_fl)
         exp_redir.tgt = EXC_VECTOR;
      else
         exp_redir.tgt = epc;

      n_fire   = (exp_redir.flush || (long0 && !finish)) ? 0 : n_ready;
      exp_fire = CMT_W'((1 << n_fire) - 1);
      exp_pop  = CMT_CNT_W'(n_fire);

      exp_mem.valid = issue && win[0].lsu_op != LSU_NONE;
      exp_mem.store = (win[0].lsu_op == LSU_STORE);
      exp_mem.addr  = win[0].opera;
      exp_mem.wdata = win[0].operb;

      exp_prf.we   = finish && !exp_redir.flush && win[0].prd_we;
      exp_prf.addr = win[0].prd;
      exp_prf.data = epu_pend ? data_t'(epc) : (mem_addr ^ RDATA_XOR);

      exp_bpu.valid   = n_fire > 0 && (win[0].is_bcc || win[0].is_brel || win[0].is_breg);
      exp_bpu.is_bcc  = win[0].is_bcc;
      exp_bpu.is_brel = win[0].is_brel;
      exp_bpu.is_breg = win[0].is_breg;
      exp_bpu.taken   = win[0].fls ? !win[0].pred_taken : win[0].pred_taken;
      exp_bpu.pc      = win[0].pc;
      exp_bpu.npc_act = win[0].fls ? win[0].fls_tgt : win[0].pred_tgt;
   endtask

   task automatic advance();
      cmt_lane_t [CMT_W-1:0] nxt;
      if (exp_redir.flush && se_pend)
         n_se++;
      if (exc_fl)
         n_exc++;
      if (exp_mem.valid)
         n_mem++;
      if (exp_prf.we)
         n_wb++;

      se_pend   = n_fire > 0 && win[0].fls;
      se_tgt    = win[0].fls_tgt;
      if (exc_fl)
         epc = win[0].pc;
      epu_pend  = issue && win[0].lsu_op == LSU_NONE;
      epu_op_q  = win[0].epu_op;
      epu_exc_q = win[0].exc;
      if (issue)
         st_pend = 1'b1;
      else if (finish)
         st_pend = 1'b0;

      if (exp_mem.valid)
      begin
         mem_wait = 1 + int'(rand_bits(2));       // Response 1 to 4 cycles later
         mem_addr = win[0].opera;
      end

      // Unfired lanes move down, a flush drops the whole window
      nxt = '0;
      if (!exp_redir.flush)
      begin
         for (int i = 0; i + n_fire < CMT_W; i++)
            nxt[i] = win[i + n_fire];
      end
      win = nxt;
      refill_window();
   endtask

   task automatic check_fire(input logic [CMT_W-1:0] exp_f,
                             input logic [CMT_CNT_W-1:0] exp_n);
      if (fire !== exp_f || pop_size !== exp_n)
         abort_run($sformatf("[ERROR] %0t: fire %b pop_size %0d, expected %b and %0d",
                             $time, fire, pop_size, exp_f, exp_n));
   endtask

   task automatic check_redirect(input redirect_t exp);
      if (redirect.flush !== exp.flush || (exp.flush && redirect.tgt !== exp.tgt))
         abort_run($sformatf("[ERROR] %0t: redirect %b/%h, expected %b/%h",
                             $time, redirect.flush, redirect.tgt, exp.flush, exp.tgt));
   endtask

   task automatic check_prf(input prf_wr_t exp);
      if (prf_wr.we !== exp.we || (exp.we && prf_wr !== exp))
         abort_run($sformatf("[ERROR] %0t: prf_wr %h, expected %h", $time, prf_wr, exp));
   endtask

   task automatic check_bpu(input bpu_upd_t exp);
      if (bpu_upd.valid !== exp.valid || (exp.valid && bpu_upd !== exp))
         abort_run($sformatf("[ERROR] %0t: bpu_upd %h, expected %h", $time, bpu_upd, exp));
   endtask

   task automatic check_mem(input mem_req_t exp);
      if (mem_req.valid !== exp.valid || (exp.valid && mem_req !== exp))
         abort_run($sformatf("[ERROR] %0t: mem_req %h, expected %h", $time, mem_req, exp));
   endtask

   initial
   begin
      #(WDOG_CYC * CLK_PERIOD);
      abort_run($sformatf("Timeout: run did not end within %0d clock cycles", WDOG_CYC));
   end

   initial
   begin
      clk       = 1'b0;
      rst       = 1'b1;
      lanes     = '0;
      mem_resp  = '0;
      lfsr      = 32'h2653d207;
      se_pend   = 1'b0;
      se_tgt    = '0;
      epu_pend  = 1'b0;
      epu_op_q  = EPU_NONE;
      epu_exc_q = 1'b0;
      st_pend   = 1'b0;
      epc       = '0;
      mem_wait  = 0;
      mem_addr  = '0;
      n_se      = 0;
      n_exc     = 0;
      n_mem     = 0;
      n_wb      = 0;
      repeat (4) @(posedge clk);
      #2;
      // Control outputs are quiet out of reset
      check_fire('0, '0);
      check_redirect('0);
      check_prf('0);
      check_bpu('0);
      check_mem('0);
      rst = 1'b0;
      win = '0;
      refill_window();

      for (int c = 0; c < N_TXN; c++)
      begin
         @(posedge clk);
         #2;
         drive_inputs();
         #20;                                     // Outputs settled
         predict();
         check_fire(exp_fire, exp_pop);
         check_redirect(exp_redir);
         check_prf(exp_prf);
         check_bpu(exp_bpu);
         check_mem(exp_mem);
         advance();
      end

      if (n_se == 0 || n_exc == 0 || n_mem == 0 || n_wb == 0)
         abort_run("Random stimulus missed a flush, memory or writeback case");
      else
      begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

//--- verification/cmt_chk.sv
/*
 * Commit stage assertions
 * A mispredict fire is followed by a flush that blocks fire, fire
 * stays a prefix of the window, and a memory request waits for the
 * previous response
 */
module cmt_chk
(
   input logic                                   clk,
   input logic                                   rst,
   input cmt_pkg::cmt_lane_t [cmt_pkg::CMT_W-1:0] lanes,
   input logic [cmt_pkg::CMT_W-1:0]              fire,
   input cmt_pkg::redirect_t                     redirect,
   input cmt_pkg::mem_req_t                      mem_req,
   input cmt_pkg::mem_resp_t                     mem_resp
);
   timeunit 1ns;
   timeprecision 1ps;
   import cmt_pkg::*;

   logic [CMT_W-1:0] fire_inc;
   logic             mem_busy;

   assign fire_inc = fire + CMT_W'(1);    // Zero AND result for 0, 1, 3, 7, 15

   always_ff @(posedge clk)
   begin
      if (rst)
         mem_busy <= 1'b0;
      else if (mem_req.valid)
         mem_busy <= 1'b1;
      else if (mem_resp.valid)
         mem_busy <= 1'b0;
   end

   a_flush_no_fire: assert property (@(posedge clk) disable iff (rst)
      fire[0] && lanes[0].fls |=> redirect.flush && fire == '0)
      else $error("no flush, or lanes fired, in the cycle after a mispredict");

   a_fire_prefix: assert property (@(posedge clk) disable iff (rst)
      (fire & fire_inc) == '0)
      else $error("fire vector is not a prefix of the lanes");

   a_one_mem_req: assert property (@(posedge clk) disable iff (rst)
      mem_req.valid |-> !mem_busy)
      else $error("second memory request before the response");

endmodule

//--- src/cmt_top.sv
/*
 * Commit stage top level
 * Connects window selection, redirect, sequencer and exception unit
 */
module cmt_top
(
   input  logic                                   clk,
   input  logic                                   rst,
   input  cmt_pkg::cmt_lane_t [cmt_pkg::CMT_W-1:0] lanes,
   input  cmt_pkg::mem_resp_t                     mem_resp,
   output logic [cmt_pkg::CMT_W-1:0]              fire,
   output logic [cmt_pkg::CMT_CNT_W-1:0]          pop_size,
   output cmt_pkg::redirect_t                     redirect,
   output cmt_pkg::prf_wr_t                       prf_wr,
   output cmt_pkg::bpu_upd_t                      bpu_upd,
   output cmt_pkg::mem_req_t                      mem_req
);
   import cmt_pkg::*;

   logic      se_busy;
   logic      cmt_ce;
   logic      lsu_req0;
   logic      epu_req0;
   logic      ready0;
   logic      epu_req;
   logic      epu_done;
   data_t     epu_dout;
   redirect_t exc_redirect;

   cmt_select u_select (
      .lanes    (lanes),
      .se_busy  (se_busy),
      .cmt_ce   (cmt_ce),
      .flush    (redirect.flush),
      .fire     (fire),
      .pop_size (pop_size),
      .lsu_req0 (lsu_req0),
      .epu_req0 (epu_req0),
      .ready0   (ready0)
   );

   cmt_redirect u_redirect (
      .clk          (clk),
      .rst          (rst),
      .lane0        (lanes[0]),
      .fire0        (fire[0]),
      .exc_redirect (exc_redirect),
      .se_busy      (se_busy),
      .redirect     (redirect),
      .bpu_upd      (bpu_upd)
   );

   cmt_seq u_seq (
      .clk      (clk),
      .rst      (rst),
      .lane0    (lanes[0]),
      .ready0   (ready0),
      .lsu_req0 (lsu_req0),
      .epu_req0 (epu_req0),
      .flush    (redirect.flush),
      .mem_resp (mem_resp),
      .epu_done (epu_done),
      .epu_dout (epu_dout),
      .cmt_ce   (cmt_ce),
      .epu_req  (epu_req),
      .mem_req  (mem_req),
      .prf_wr   (prf_wr)
   );

   cmt_epu u_epu (
      .clk          (clk),
      .rst          (rst),
      .epu_req      (epu_req),
      .lane0        (lanes[0]),
      .epu_done     (epu_done),
      .epu_dout     (epu_dout),
      .exc_redirect (exc_redirect)
   );

endmodule

//--- src/cmt_epu.sv
/*
 * Exception unit
 * Answers a request one cycle later, keeps the EPC register and
 * redirects on system calls, exceptions and return from exception
 */
module cmt_epu
(
   input  logic                clk,
   input  logic                rst,
   input  logic                epu_req,
   input  cmt_pkg::cmt_lane_t  lane0,
   output logic                epu_done,
   output cmt_pkg::data_t      epu_dout,
   output cmt_pkg::redirect_t  exc_redirect
);
   import cmt_pkg::*;

   logic    req_q;
   epu_op_e op_q;
   logic    exc_q;
   pc_t     epc_q;
   logic    take_exc;
   logic    do_eret;

   always_ff @(posedge clk)
   begin
      if (rst)
         req_q <= 1'b0;
      else
         req_q <= epu_req;
   end

   always_ff @(posedge clk)
   begin
      if (epu_req)
      begin
         op_q  <= lane0.epu_op;
         exc_q <= lane0.exc;
      end
   end

   assign take_exc = req_q & (exc_q | (op_q == EPU_SYSCALL));
   assign do_eret  = req_q & ~exc_q & (op_q == EPU_ERET);

   // Lane 0 is still held in the done cycle, so its pc is valid here
   always_ff @(posedge clk)
   begin
      if (rst)
         epc_q <= '0;
      else if (take_exc)
         epc_q <= lane0.pc;
   end

   assign epu_done = req_q;
   assign epu_dout = {{(DW-PC_W){1'b0}}, epc_q};

   assign exc_redirect.flush = take_exc | do_eret;
   assign exc_redirect.tgt   = take_exc ? EXC_VECTOR : epc_q;

endmodule

//--- src/cmt_seq.sv
/*
 * Long operation sequencer for lane 0
 * Issues one load/store or exception unit request, holds lane 0
 * until it finishes, and writes the result back
 */
module cmt_seq
(
   input  logic                clk,
   input  logic                rst,
   input  cmt_pkg::cmt_lane_t  lane0,
   input  logic                ready0,
   input  logic                lsu_req0,
   input  logic                epu_req0,
   input  logic                flush,
   input  cmt_pkg::mem_resp_t  mem_resp,
   input  logic                epu_done,
   input  cmt_pkg::data_t      epu_dout,
   output logic                cmt_ce,
   output logic                epu_req,
   output cmt_pkg::mem_req_t   mem_req,
   output cmt_pkg::prf_wr_t    prf_wr
);
   import cmt_pkg::*;

   seq_state_e state_q;
   seq_state_e state_d;
   logic       long_op;
   logic       finish;
   logic       issue;

   assign long_op = ready0 & (lsu_req0 | epu_req0);
   assign finish  = mem_resp.valid | epu_done;

   // Lane 0 is held until its long op completes
   assign cmt_ce = ~long_op | finish;

   assign issue = (state_q == S_IDLE) & long_op;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         S_IDLE:
         begin
            if (long_op)
               state_d = S_PENDING;
         end
         S_PENDING:
         begin
            if (finish)
               state_d = S_IDLE;
         end
         default:
            state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state_q <= S_IDLE;
      else
         state_q <= state_d;
   end

   // Load/store takes the memory port, anything else goes to the EPU
   assign epu_req = issue & ~lsu_req0;

   always_comb
   begin
      mem_req.valid = issue & lsu_req0;
      mem_req.store = (lane0.lsu_op == LSU_STORE);
      mem_req.addr  = lane0.opera;
      mem_req.wdata = lane0.operb;
   end

   always_comb
   begin
      prf_wr.we   = finish & ~flush & lane0.prd_we;
      prf_wr.addr = lane0.prd;
      prf_wr.data = epu_done ? epu_dout : mem_resp.rdata;   // EPC read or load data
   end

endmodule

//--- src/cmt_redirect.sv
/*
 * Speculative redirect and predictor update
 * Registers a lane 0 mispredict for one cycle, merges it with the
 * exception redirect, and forms the branch predictor update
 */
module cmt_redirect
(
   input  logic                clk,
   input  logic                rst,
   input  cmt_pkg::cmt_lane_t  lane0,
   input  logic                fire0,
   input  cmt_pkg::redirect_t  exc_redirect,
   output logic                se_busy,
   output cmt_pkg::redirect_t  redirect,
   output cmt_pkg::bpu_upd_t   bpu_upd
);
   import cmt_pkg::*;

   logic se_fls_q;
   pc_t  se_tgt_q;
   logic is_br0;

   // Flush never coincides with fire, so the flag lasts one cycle
   always_ff @(posedge clk)
   begin
      if (rst)
         se_fls_q <= 1'b0;
      else
         se_fls_q <= fire0 & lane0.fls;
   end

   always_ff @(posedge clk)
   begin
      if (fire0)
         se_tgt_q <= lane0.fls_tgt;
   end

   assign se_busy = se_fls_q;

   // Mispredict outranks the exception unit
   assign redirect.flush = se_fls_q | exc_redirect.flush;
   assign redirect.tgt   = se_fls_q ? se_tgt_q : exc_redirect.tgt;

   assign is_br0 = lane0.is_bcc | lane0.is_brel | lane0.is_breg;

   always_comb
   begin
      bpu_upd.valid   = fire0 & is_br0;
      bpu_upd.is_bcc  = lane0.is_bcc;
      bpu_upd.is_brel = lane0.is_brel;
      bpu_upd.is_breg = lane0.is_breg;
      bpu_upd.taken   = lane0.pred_taken ^ lane0.fls;     // Wrong guess flips it
      bpu_upd.pc      = lane0.pc;
      bpu_upd.npc_act = lane0.fls ? lane0.fls_tgt : lane0.pred_tgt;
   end

endmodule

//--- src/cmt_select.sv
/*
 * Commit window selection
 * Decodes single-issue lanes, builds the in-order commit mask,
 * and produces the fire vector and its count
 */
module cmt_select
(
   input  cmt_pkg::cmt_lane_t [cmt_pkg::CMT_W-1:0] lanes,
   input  logic                                   se_busy,
   input  logic                                   cmt_ce,
   input  logic                                   flush,
   output logic [cmt_pkg::CMT_W-1:0]              fire,
   output logic [cmt_pkg::CMT_CNT_W-1:0]          pop_size,
   output logic                                   lsu_req0,
   output logic                                   epu_req0,
   output logic                                   ready0
);
   import cmt_pkg::*;

   logic [CMT_W-1:0] lsu_req;
   logic [CMT_W-1:0] epu_req;
   logic [CMT_W-1:0] is_br;
   logic [CMT_W-1:0] single;
   logic [CMT_W-1:0] mask;
   logic [CMT_W-1:0] ready;

   for (genvar i = 0; i < CMT_W; i++)
   begin : g_lane
      // Long op requests are dropped while a speculative flush drains
      assign lsu_req[i] = ~se_busy & (lanes[i].lsu_op != LSU_NONE);
      assign epu_req[i] = ~se_busy & ((lanes[i].epu_op != EPU_NONE) | lanes[i].exc);
      assign is_br[i]   = lanes[i].is_bcc | lanes[i].is_brel | lanes[i].is_breg;
      assign single[i]  = lsu_req[i] | epu_req[i] | lanes[i].fls | is_br[i];
   end

   // Single-issue lanes may only retire from lane 0, and block younger lanes
   always_comb
   begin
      mask[0] = 1'b1;
      mask[1] = ~single[0] & ~single[1];
      for (int i = 2; i < CMT_W; i++)
      begin
         mask[i] = mask[i-1] & ~single[i];
      end
   end

   for (genvar i = 0; i < CMT_W; i++)
   begin : g_ready
      assign ready[i] = lanes[i].valid & mask[i];
   end

   assign fire = ready & {CMT_W{cmt_ce & ~flush}};

   always_comb
   begin
      pop_size = '0;
      for (int i = 0; i < CMT_W; i++)
      begin
         pop_size = pop_size + CMT_CNT_W'(fire[i]);
      end
   end

   assign lsu_req0 = lsu_req[0];
   assign epu_req0 = epu_req[0];
   assign ready0   = ready[0];

endmodule

//--- src/cmt_pkg.sv
/*
 * Commit stage package
 * Widths, lane count, exception vector, opcode and state enums,
 * and the packed structs shared by the commit blocks
 */
package cmt_pkg;

   localparam int CMT_W     = 4;        // Commit lanes
   localparam int CMT_CNT_W = 3;        // Holds 0..CMT_W
   localparam int PC_W      = 30;       // Word PC
   localparam int DW        = 32;
   localparam int PRF_AW    = 6;

   typedef logic [PC_W-1:0]   pc_t;
   typedef logic [DW-1:0]     data_t;
   typedef logic [PRF_AW-1:0] prf_addr_t;

   // System calls and exceptions land here
   localparam pc_t EXC_VECTOR = 30'h0000_0040;

   typedef enum logic [1:0] {
      LSU_NONE,
      LSU_LOAD,
      LSU_STORE
   } lsu_op_e;

   typedef enum logic [1:0] {
      EPU_NONE,
      EPU_SYSCALL,
      EPU_ERET,
      EPU_RDEPC
   } epu_op_e;

   typedef enum logic {
      S_IDLE,
      S_PENDING
   } seq_state_e;

   // One reorder buffer head entry
   typedef struct packed {
      logic      valid;
      lsu_op_e   lsu_op;
      epu_op_e   epu_op;
      logic      exc;          // Exception raised earlier in the pipe
      logic      is_bcc;
      logic      is_brel;
      logic      is_breg;
      logic      fls;          // Mispredicted
      pc_t       fls_tgt;      // Resolved target
      pc_t       pc;
      prf_addr_t prd;
      logic      prd_we;
      data_t     opera;        // Load/store address
      data_t     operb;        // Store data
      logic      pred_taken;
      pc_t       pred_tgt;
   } cmt_lane_t;

   typedef struct packed {
      logic flush;
      pc_t  tgt;
   } redirect_t;

   typedef struct packed {
      logic valid;
      logic is_bcc;
      logic is_brel;
      logic is_breg;
      logic taken;
      pc_t  pc;
      pc_t  npc_act;
   } bpu_upd_t;

   typedef struct packed {
      logic      we;
      prf_addr_t addr;
      data_t     data;
   } prf_wr_t;

   typedef struct packed {
      logic  valid;
      logic  store;
      data_t addr;
      data_t wdata;
   } mem_req_t;

   typedef struct packed {
      logic  valid;
      data_t rdata;
   } mem_resp_t;

endpackage
